// File: hw/board_pkg.sv
package board_pkg;

	////////////////////
	// keypad
	localparam int KEYPAD_WIDTH = 4;                // rows and columns

	typedef logic [3:0] key_code_t;                 // row * 4 + column

	typedef struct packed {
		key_code_t key;                             // lowest closed key of the sweep
		logic      pressed;                         // any key closed
	} key_report_t;

	////////////////////
	// audio
	typedef logic [5:0] note_code_t;                // 1..24 play, rest silent
	typedef logic signed [15:0] audio_sample_t;

	typedef struct packed {
		audio_sample_t left;                        // sent first, ws low
		audio_sample_t right;                       // ws high
	} stereo_sample_t;

	localparam audio_sample_t TONE_AMPLITUDE = 16'sh2000; // square wave swing

	// frames per half period, 0 for silence
	function automatic logic [5:0] note_half_frames(note_code_t note);
		logic [5:0] half;
		if (note >= 6'd1 && note <= 6'd24)
			half = note + 6'd1;
		else
			half = 6'd0;
		return half;
	endfunction

	////////////////////
	// display
	typedef logic [5:0] letter_code_t;              // 0..9 digits, 10..35 A..Z
	typedef logic [14:0] seg14_t;                   // active low, 0 lights the segment

	// bit order a b c d e f / g1 g2 / h j k / l m n / dp
	function automatic seg14_t letter_glyph(letter_code_t code);
		seg14_t glyph;
		case (code)
			6'd0:  glyph = 15'b000000_11_110_011_1; // 0 with slash
			6'd1:  glyph = 15'b100111_11_111_111_1;
			6'd2:  glyph = 15'b001001_00_111_111_1;
			6'd3:  glyph = 15'b000011_10_111_111_1;
			6'd4:  glyph = 15'b100110_00_111_111_1;
			6'd5:  glyph = 15'b010010_00_111_111_1;
			6'd6:  glyph = 15'b010000_00_111_111_1;
			6'd7:  glyph = 15'b000111_11_111_111_1;
			6'd8:  glyph = 15'b000000_00_111_111_1;
			6'd9:  glyph = 15'b000010_00_111_111_1;
			6'd10: glyph = 15'b000100_00_111_111_1; // A
			6'd11: glyph = 15'b000011_10_101_101_1; // B
			6'd12: glyph = 15'b011000_11_111_111_1; // C
			6'd13: glyph = 15'b000011_11_101_101_1; // D
			6'd14: glyph = 15'b011000_01_111_111_1; // E
			6'd15: glyph = 15'b011100_01_111_111_1; // F
			6'd16: glyph = 15'b010000_10_111_111_1; // G
			6'd17: glyph = 15'b100100_00_111_111_1; // H
			6'd18: glyph = 15'b011011_11_101_101_1; // I
			6'd19: glyph = 15'b100001_11_111_111_1; // J
			6'd20: glyph = 15'b111100_01_110_110_1; // K
			6'd21: glyph = 15'b111000_11_111_111_1; // L
			6'd22: glyph = 15'b100100_11_010_111_1; // M
			6'd23: glyph = 15'b100100_11_011_110_1; // N
			6'd24: glyph = 15'b000000_11_111_111_1; // O
			6'd25: glyph = 15'b001100_00_111_111_1; // P
			6'd26: glyph = 15'b000000_11_111_110_1; // Q
			6'd27: glyph = 15'b001100_00_111_110_1; // R
			6'd28: glyph = 15'b010011_10_011_111_1; // S
			6'd29: glyph = 15'b011111_11_101_101_1; // T
			6'd30: glyph = 15'b100000_11_111_111_1; // U
			6'd31: glyph = 15'b111100_11_110_011_1; // V
			6'd32: glyph = 15'b100100_11_111_010_1; // W
			6'd33: glyph = 15'b111111_11_010_010_1; // X
			6'd34: glyph = 15'b111111_11_010_101_1; // Y
			6'd35: glyph = 15'b011011_11_110_011_1; // Z
			default: glyph = '1;                    // blank
		endcase
		return glyph;
	endfunction

endpackage

// File: hw/tick_gen.sv
`timescale 1ns/1ps

module tick_gen #(
	parameter int SCAN_DIV  = 8,                    // clk cycles per row
	parameter int DIGIT_DIV = 16                    // clk cycles per digit
) (
	input  logic clk,
	input  logic arst_n,
	output logic scan_tick,
	output logic digit_tick
);

	localparam int DIV [2] = '{SCAN_DIV, DIGIT_DIV};

	logic [1:0] ticks;                              // 0 scan, 1 digit

	for (genvar i = 0; i < 2; i++) begin : g_div
		localparam int W = $clog2(DIV[i]);
		logic [W-1:0] cnt;                          // free-running

		always_ff @(posedge clk or negedge arst_n) begin
			if (!arst_n) begin
				cnt      <= '0;
				ticks[i] <= 1'b0;
			end else begin
				cnt      <= (cnt == W'(DIV[i] - 1)) ? '0 : cnt + 1'b1;
				ticks[i] <= (cnt == W'(DIV[i] - 1)); // strobe at wrap
			end
		end

		// a strobe is never longer than one cycle
		a_single_cycle: assert property (@(posedge clk) disable iff (!arst_n)
			ticks[i] |=> !ticks[i]);
	end

	assign scan_tick  = ticks[0];
	assign digit_tick = ticks[1];

endmodule

// File: hw/keypad_scan.sv
`timescale 1ns/1ps

module keypad_scan (
	input  logic                                clk,
	input  logic                                arst_n,
	input  logic                                scan_tick,
	input  logic [board_pkg::KEYPAD_WIDTH-1:0] col_n,
	output logic [board_pkg::KEYPAD_WIDTH-1:0] row_n,
	output board_pkg::key_report_t             key_report
);

	import board_pkg::*;

	localparam int ROW_W = $clog2(KEYPAD_WIDTH);
	localparam int KEYS  = KEYPAD_WIDTH * KEYPAD_WIDTH;

	logic [ROW_W-1:0] row_idx;                      // row under scan
	logic [KEYS-1:0]  hits;                         // one slot per row by key code
	logic [KEYS-1:0]  hits_all;                     // plus the row under scan
	logic             last_row;
	key_report_t      sweep_report;

	assign row_n    = ~(KEYPAD_WIDTH'(1) << row_idx); // one row low
	assign last_row = (row_idx == ROW_W'(KEYPAD_WIDTH - 1));

	////////////////////
	// lowest closed key of the sweep
	always_comb begin
		hits_all = hits;
		hits_all[row_idx*KEYPAD_WIDTH +: KEYPAD_WIDTH] = ~col_n; // low col is closed
		sweep_report = '0;
		for (int i = KEYS - 1; i >= 0; i--) begin   // last hit wins and is the lowest
			if (hits_all[i]) begin
				sweep_report.key     = key_code_t'(i);
				sweep_report.pressed = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			row_idx    <= '0;
			hits       <= '0;
			key_report <= '0;
		end else if (scan_tick) begin
			row_idx <= last_row ? '0 : row_idx + 1'b1;
			if (last_row) begin
				key_report <= sweep_report;        // publish once per sweep
				hits       <= '0;                  // fresh sweep
			end else begin
				hits <= hits_all;
			end
		end
	end

	a_one_row: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot(~row_n));

endmodule

// File: hw/tone_gen.sv
`timescale 1ns/1ps

module tone_gen (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      frame_start,
	input  board_pkg::note_code_t     note,
	output board_pkg::stereo_sample_t sample
);

	import board_pkg::*;

	note_code_t    note_r;                          // note being played
	logic [5:0]    frame_cnt;                       // frames since last flip
	logic [5:0]    half_frames;                     // 0 means silence
	logic          polarity;                        // 1 for negative half
	audio_sample_t level;

	assign half_frames = note_half_frames(note_r);

	////////////////////
	// frame counting, one step per audio frame
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			note_r    <= '0;
			frame_cnt <= '0;
			polarity  <= 1'b0;
		end else if (frame_start) begin
			if (note != note_r) begin
				note_r    <= note;                 // new note restarts the count
				frame_cnt <= '0;
			end else if (half_frames == '0) begin
				frame_cnt <= '0;                   // silent
			end else if (frame_cnt == half_frames - 6'd1) begin
				frame_cnt <= '0;
				polarity  <= ~polarity;            // half period done
			end else begin
				frame_cnt <= frame_cnt + 6'd1;
			end
		end
	end

	always_comb begin
		if (half_frames == '0)
			level = '0;
		else if (polarity)
			level = -TONE_AMPLITUDE;
		else
			level = TONE_AMPLITUDE;
		sample.left  = level;                      // mono on both channels
		sample.right = level;
	end

endmodule

// File: hw/audio_serializer.sv
`timescale 1ns/1ps

module audio_serializer (
	input  logic                      clk,
	input  logic                      arst_n,
	input  board_pkg::stereo_sample_t sample,
	output logic                      frame_start,
	output logic                      audio_bck,
	output logic                      audio_ws,
	output logic                      audio_data
);

	import board_pkg::*;

	localparam int SAMPLE_W = $bits(stereo_sample_t); // 32 bits per frame

	logic [5:0]          cyc;                       // 64 clk cycles per frame
	stereo_sample_t      hold;                      // sample for next frame
	logic [SAMPLE_W-1:0] shreg;                     // MSB on the line

	assign frame_start = (cyc == 6'd0);
	assign audio_bck   = cyc[0];                    // low on even cycles
	assign audio_ws    = cyc[5];                    // left half then right half
	assign audio_data  = shreg[SAMPLE_W-1];

	////////////////////
	// frame counter and shifter
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cyc   <= '0;
			shreg <= '0;
		end else begin
			cyc <= cyc + 6'd1;
			if (cyc == 6'd63)
				shreg <= hold;                     // load for next frame
			else if (cyc[0])
				shreg <= shreg << 1;               // next bit as bck falls
		end
	end

	// tone_gen output settles on the cycle after frame_start
	always_ff @(posedge clk) begin
		if (cyc == 6'd1)
			hold <= sample;
	end

	////////////////////
	// DAC framing
	a_ws_on_low_bck: assert property (@(posedge clk) disable iff (!arst_n)
		$changed(audio_ws) |-> !audio_bck);

endmodule

// File: hw/ssd_scan.sv
`timescale 1ns/1ps

module ssd_scan (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    digit_tick,
	input  board_pkg::letter_code_t letter1,
	input  board_pkg::letter_code_t letter2,
	output board_pkg::seg14_t       display,
	output logic [1:0]              control
);

	import board_pkg::*;

	logic         digit_sel;                        // 0 left digit, 1 right digit
	logic         next_sel;
	letter_code_t letter;                           // letter for next cycle

	assign next_sel = digit_sel ^ digit_tick;       // flip on each tick
	assign letter   = next_sel ? letter2 : letter1;
	assign control  = digit_sel ? 2'b01 : 2'b10;    // active low enables

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			digit_sel <= 1'b0;
		else
			digit_sel <= next_sel;
	end

	// glyph follows the select in the same cycle as control
	always_ff @(posedge clk) begin
		display <= letter_glyph(letter);
	end

endmodule

// File: hw/secondary_board.sv
`timescale 1ns/1ps

module secondary_board #(
	parameter int SCAN_DIV  = 8,                    // clk cycles per keypad row
	parameter int DIGIT_DIV = 16                    // clk cycles per display digit
) (
	input  logic                                clk,
	input  logic                                arst_n,
	input  logic                                peer_arst_n,     // from main board
	output logic                                peer_arst_out_n, // to main board
	input  board_pkg::note_code_t               note_in,
	input  board_pkg::letter_code_t             letter1,
	input  board_pkg::letter_code_t             letter2,
	input  logic [board_pkg::KEYPAD_WIDTH-1:0] col_n,
	output logic [board_pkg::KEYPAD_WIDTH-1:0] row_n,
	output board_pkg::key_report_t             key_report,
	output board_pkg::seg14_t                  display,
	output logic [1:0]                          control,
	output logic                                audio_bck,
	output logic                                audio_ws,
	output logic                                audio_data
);

	import board_pkg::*;

	logic           core_arst_n;                    // either board resets us
	logic           scan_tick;
	logic           digit_tick;
	logic           frame_start;
	stereo_sample_t sample;

	assign core_arst_n     = arst_n & peer_arst_n;
	assign peer_arst_out_n = arst_n;                // own reset only

	////////////////////
	// strobes
	tick_gen #(
		.SCAN_DIV  (SCAN_DIV),
		.DIGIT_DIV (DIGIT_DIV)
	) u_tick_gen (
		.clk        (clk),
		.arst_n     (core_arst_n),
		.scan_tick  (scan_tick),
		.digit_tick (digit_tick)
	);

	keypad_scan u_keypad_scan (
		.clk        (clk),
		.arst_n     (core_arst_n),
		.scan_tick  (scan_tick),
		.col_n      (col_n),
		.row_n      (row_n),
		.key_report (key_report)
	);

	////////////////////
	// tone path
	tone_gen u_tone_gen (
		.clk         (clk),
		.arst_n      (core_arst_n),
		.frame_start (frame_start),
		.note        (note_in),
		.sample      (sample)
	);

	audio_serializer u_audio_serializer (
		.clk         (clk),
		.arst_n      (core_arst_n),
		.sample      (sample),
		.frame_start (frame_start),
		.audio_bck   (audio_bck),
		.audio_ws    (audio_ws),
		.audio_data  (audio_data)
	);

	ssd_scan u_ssd_scan (
		.clk        (clk),
		.arst_n     (core_arst_n),
		.digit_tick (digit_tick),
		.letter1    (letter1),
		.letter2    (letter2),
		.display    (display),
		.control    (control)
	);

endmodule

// File: dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter real PERIOD_NS = 4.0                  // clk period
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always #(PERIOD_NS / 2.0) clk = ~clk;           // free-running at 50 % duty

endmodule

// File: dv/secondary_board_tb.sv
`timescale 1ns/1ps

module secondary_board_tb;

	import board_pkg::*;

	typedef struct packed {
		note_code_t   note;
		letter_code_t let1;
		letter_code_t let2;
		logic [15:0]  keys;                         // held keys by key code
		logic         peer_rst;                     // pulse peer reset at row start
	} stim_t;

	localparam int N_FIXED       = 8;
	localparam int N_ROWS        = N_FIXED + 4;     // plus random rows
	localparam int RESET_CYCLES  = 16;
	localparam int FRAME_CYCLES  = 64;
	localparam int SWEEP_CYCLES  = KEYPAD_WIDTH * 8; // default SCAN_DIV
	localparam int SETTLE_FRAMES = 3;               // frames still carrying the old note
	localparam int ROW_BUDGET    = 4 * SWEEP_CYCLES + 60 * FRAME_CYCLES;
	localparam int CYCLE_LIMIT   = RESET_CYCLES + N_ROWS * ROW_BUDGET + 2000;

	logic                    clk;
	logic                    arst_n;
	logic                    peer_arst_n;
	logic                    peer_arst_out_n;
	note_code_t              note_in;
	letter_code_t            letter1;
	letter_code_t            letter2;
	logic [KEYPAD_WIDTH-1:0] col_n;
	logic [KEYPAD_WIDTH-1:0] row_n;
	key_report_t             key_report;
	seg14_t                  display;
	logic [1:0]              control;
	logic                    audio_bck;
	logic                    audio_ws;
	logic                    audio_data;
	logic                    rst_any;               // core reset as seen by the DUT
	logic [15:0]             key_mask = '0;
	stim_t                   stim_table [N_ROWS];
	int                      errors = 0;
	int                      cycle_count = 0;
	int                      note_epoch = 0;        // bumped on each new note
	int                      seg_checks = 0;
	logic [1:0]              prev_ctl = 2'b10;
	// frame monitor state
	int                      bit_idx = 0;
	logic [31:0]             frame_bits = '0;
	int                      tone_epoch = -1;
	int                      since = 0;
	int                      run = 0;
	int                      zero_frames = 0;
	bit                      flip_seen = 1'b0;
	bit                      have_prev = 1'b0;
	bit                      tone_ok = 1'b0;
	audio_sample_t           prev_level = '0;

	assign rst_any = arst_n & peer_arst_n;

	tb_clock #(.PERIOD_NS(4.0)) u_tb_clock (.clk(clk));

	secondary_board u_secondary_board (
		.clk             (clk),
		.arst_n          (arst_n),
		.peer_arst_n     (peer_arst_n),
		.peer_arst_out_n (peer_arst_out_n),
		.note_in         (note_in),
		.letter1         (letter1),
		.letter2         (letter2),
		.col_n           (col_n),
		.row_n           (row_n),
		.key_report      (key_report),
		.display         (display),
		.control         (control),
		.audio_bck       (audio_bck),
		.audio_ws        (audio_ws),
		.audio_data      (audio_data)
	);

	// switch matrix where a closed key pulls its column to the driven row
	always_comb begin
		col_n = '1;
		for (int r = 0; r < KEYPAD_WIDTH; r++)
			if (!row_n[r])
				col_n = col_n & ~key_mask[r*KEYPAD_WIDTH +: KEYPAD_WIDTH];
	end

	////////////////////
	// reporting
	task automatic abort_run(input string why);
		errors++;
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_report(input string name, input key_report_t exp,
			input key_report_t act);
		if (act !== exp)
			abort_run($sformatf(
				"FAIL t=%0t %s expected key=%0d pressed=%0b actual key=%0d pressed=%0b",
				$time, name, exp.key, exp.pressed, act.key, act.pressed));
	endtask

	task automatic check_seg(input seg14_t exp_disp, input seg14_t act_disp,
			input logic [1:0] exp_ctl, input logic [1:0] act_ctl);
		if (act_ctl !== exp_ctl)
			abort_run($sformatf("FAIL t=%0t control expected %b actual %b",
				$time, exp_ctl, act_ctl));
		if (act_disp !== exp_disp)
			abort_run($sformatf("FAIL t=%0t display expected %h actual %h",
				$time, exp_disp, act_disp));
	endtask

	task automatic check_sample(input string name, input audio_sample_t exp,
			input audio_sample_t act);
		if (act !== exp)
			abort_run($sformatf("FAIL t=%0t %s expected %0d actual %0d", $time, name, exp, act));
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp)
			abort_run($sformatf("FAIL t=%0t %s expected %0d actual %0d", $time, name, exp, act));
	endtask

	task automatic check_bits(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
			abort_run($sformatf("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act));
	endtask

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT)
			abort_run($sformatf("TIMEOUT: no end of test after %0d clock cycles", CYCLE_LIMIT));
	end

	////////////////////
	// expected values
	// first closed key in row-major order with code row * 4 + column
	function automatic key_report_t lowest_key(input logic [15:0] mask);
		key_report_t rep;
		rep = '0;
		for (int r = 0; r < KEYPAD_WIDTH; r++)
			for (int c = 0; c < KEYPAD_WIDTH; c++)
				if (mask[r*KEYPAD_WIDTH+c] && !rep.pressed) begin
					rep.key     = key_code_t'(r * KEYPAD_WIDTH + c);
					rep.pressed = 1'b1;
				end
		return rep;
	endfunction

	// codes past Z stay dark
	function automatic seg14_t expected_glyph(input letter_code_t code);
		seg14_t glyph;
		if (code > 6'd35)
			glyph = '1;
		else
			glyph = letter_glyph(code);
		return glyph;
	endfunction

	////////////////////
	// display monitor with one check per digit change
	always @(negedge clk) begin
		logic [1:0] exp_ctl;
		if (rst_any && control !== prev_ctl) begin
			exp_ctl = (prev_ctl == 2'b10) ? 2'b01 : 2'b10; // digits alternate
			check_seg((exp_ctl == 2'b10) ? expected_glyph(letter1) : expected_glyph(letter2),
				display, exp_ctl, control);
			seg_checks++;
		end
		prev_ctl = control;
	end

	////////////////////
	// audio frame monitor
	task automatic take_frame(input stereo_sample_t s);
		audio_sample_t exp_level;
		logic [5:0]    half;
		check_sample("audio_right", s.left, s.right); // mono tone
		if (tone_epoch != note_epoch) begin         // new note or reset starts over
			tone_epoch  = note_epoch;
			since       = 0;
			run         = 0;
			zero_frames = 0;
			flip_seen   = 1'b0;
			have_prev   = 1'b0;
			tone_ok     = 1'b0;
		end
		since++;
		if (since > SETTLE_FRAMES) begin
			half = note_half_frames(note_in);
			if (half == 6'd0) begin
				check_sample("audio_left", '0, s.left); // silence
				zero_frames++;
				if (zero_frames >= 4)
					tone_ok = 1'b1;
			end else begin
				exp_level = s.left[15] ? -TONE_AMPLITUDE : TONE_AMPLITUDE;
				check_sample("audio_left", exp_level, s.left);
				if (have_prev && s.left != prev_level) begin
					if (flip_seen) begin
						check_count("flip_spacing", int'(half), run);
						tone_ok = 1'b1;
					end
					flip_seen = 1'b1;
					run       = 0;
				end
				run++;
				prev_level = s.left;
				have_prev  = 1'b1;
			end
		end
	endtask

	always @(posedge audio_bck or negedge rst_any) begin
		if (!rst_any) begin
			bit_idx    = 0;
			tone_epoch = -1;                        // resync after reset
			tone_ok    = 1'b0;
		end else begin
			check_bits("audio_ws", 8'(bit_idx >= 16), 8'(audio_ws));
			frame_bits = {frame_bits[30:0], audio_data}; // MSB first
			bit_idx++;
			if (bit_idx == 32) begin
				bit_idx = 0;
				take_frame(stereo_sample_t'(frame_bits));
			end
		end
	end

	////////////////////
	// stimulus
	task automatic wait_sweep_end();
		@(negedge clk);
		while (row_n !== 4'b0111)                   // row 3 under scan
			@(negedge clk);
		while (row_n !== 4'b1110)                   // report moves with this step
			@(negedge clk);
	endtask

	task automatic check_idle(input logic exp_peer_out);
		check_bits("row_n", 8'(4'b1110), 8'(row_n));
		check_bits("audio_pins", 8'h00, {5'b0, audio_ws, audio_bck, audio_data});
		check_bits("peer_arst_out_n", {7'b0, exp_peer_out}, {7'b0, peer_arst_out_n});
		check_report("key_report", '0, key_report);
		check_seg(expected_glyph(letter1), display, 2'b10, control);
	endtask

	task automatic pulse_peer_reset();
		@(negedge clk);
		peer_arst_n <= 1'b0;
		repeat (4) @(negedge clk);
		check_idle(1'b1);                           // own reset is still high
		peer_arst_n <= 1'b1;
	endtask

	task automatic apply_row(input stim_t s);
		int seg_start;
		@(negedge clk);
		note_in <= s.note;
		letter1 <= s.let1;
		letter2 <= s.let2;
		note_epoch++;
		if (s.peer_rst)
			pulse_peer_reset();
		seg_start = seg_checks;
		key_mask <= s.keys;
		if (s.keys != '0) begin
			while (!key_report.pressed)
				@(negedge clk);
			wait_sweep_end();                       // first sweep may be partial
			check_report("key_report", lowest_key(s.keys), key_report);
		end else begin
			wait_sweep_end();
			wait_sweep_end();
			check_report("key_report", '0, key_report);
		end
		while (!(tone_epoch == note_epoch && tone_ok))
			@(negedge clk);
		while (seg_checks < seg_start + 3)
			@(negedge clk);
		@(negedge clk);
		key_mask <= '0;                             // release
		wait_sweep_end();
		wait_sweep_end();
		check_report("key_report", '0, key_report);
	endtask

	task automatic fill_table();
		stim_table[0] = '{note: 6'd1,  let1: 6'd10, let2: 6'd11, keys: 16'h0000, peer_rst: 1'b0};
		stim_table[1] = '{note: 6'd5,  let1: 6'd0,  let2: 6'd9,  keys: 16'h0020, peer_rst: 1'b0};
		stim_table[2] = '{note: 6'd0,  let1: 6'd35, let2: 6'd36, keys: 16'h8000, peer_rst: 1'b0};
		stim_table[3] = '{note: 6'd24, let1: 6'd12, let2: 6'd13, keys: 16'h0204, peer_rst: 1'b0};
		stim_table[4] = '{note: 6'd30, let1: 6'd63, let2: 6'd20, keys: 16'h0001, peer_rst: 1'b1};
		stim_table[5] = '{note: 6'd12, let1: 6'd22, let2: 6'd23, keys: 16'h1080, peer_rst: 1'b0};
		stim_table[6] = '{note: 6'd2,  let1: 6'd1,  let2: 6'd2,  keys: 16'h1000, peer_rst: 1'b0};
		stim_table[7] = '{note: 6'd17, let1: 6'd33, let2: 6'd34, keys: 16'h0400, peer_rst: 1'b1};
		for (int i = N_FIXED; i < N_ROWS; i++) begin // random letters, notes and one key
			stim_table[i].note     = 6'($urandom % 32);
			stim_table[i].let1     = 6'($urandom % 64);
			stim_table[i].let2     = 6'($urandom % 64);
			stim_table[i].keys     = 16'h0001 << ($urandom % 16);
			stim_table[i].peer_rst = 1'b0;
		end
	endtask

	initial begin
		arst_n      = 1'b0;
		peer_arst_n = 1'b1;
		note_in     = '0;
		letter1     = '0;
		letter2     = '0;
		void'($urandom(32'h6827));
		fill_table();
		repeat (RESET_CYCLES) @(negedge clk);
		check_idle(1'b0);                           // forwarded reset is low too
		arst_n <= 1'b1;
		for (int r = 0; r < N_ROWS; r++)
			apply_row(stim_table[r]);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// File: files.f
hw/board_pkg.sv
hw/tick_gen.sv
hw/keypad_scan.sv
hw/tone_gen.sv
hw/audio_serializer.sv
hw/ssd_scan.sv
hw/secondary_board.sv
dv/tb_clock.sv
dv/secondary_board_tb.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f files.f \
	--top-module secondary_board_tb -o sim > sim.log 2>&1 &&
	./obj_dir/sim >> sim.log 2>&1
status=$?
! grep -q '\*\*\* FAILED \*\*\*' sim.log && [ "$status" -eq 0 ] &&
	echo "simulation passed" || { echo "simulation failed, see sim.log"; exit 1; }
